/* rtl/gen_pkg.sv */
////////////////////////////////////////////////////////////
// arbitrary signal generator, shared definitions
// widths, sample/pointer types, bus and stream beats,
// register map and core states
////////////////////////////////////////////////////////////

package gen_pkg;

  localparam int unsigned DW  = 14;         // DAC sample width
  localparam int unsigned CWM = 14;         // pointer integer part
  localparam int unsigned CWF = 16;         // pointer fraction part
  localparam int unsigned CW  = CWM + CWF;  // full pointer
  localparam int unsigned CWL = 32;         // burst period counter
  localparam int unsigned CWN = 16;         // burst repeat counter
  localparam int unsigned BAW = 7;          // register address bits

  typedef logic signed [DW-1:0] smp_t;      // signed DAC sample
  typedef logic [CW-1:0]        ptr_t;      // fixed point table pointer
  typedef logic [CWM-1:0]       tbl_adr_t;  // table index
  typedef logic [BAW-1:0]       reg_adr_t;

  typedef struct packed {
    logic        wen;
    logic        ren;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic vld;
    smp_t dat;
  } stm_t;

  // one clock controls
  typedef struct packed {
    logic clr;
    logic str;
    logic stp;
    logic trg;
  } ctl_t;

  typedef struct packed {
    ptr_t           siz;  // table size
    ptr_t           off;  // start phase
    ptr_t           ste;  // step, sets frequency
    logic           ben;  // burst enable
    logic           inf;  // infinite burst
    tbl_adr_t       bdl;  // data beats per period
    logic [CWL-1:0] bln;  // period length in beats
    logic [CWN-1:0] bnm;  // period count
  } gen_cfg_t;

  typedef struct packed {
    logic signed [DW-1:0] mul;  // gain, 1.0 = 2**(DW-2)
    logic signed [DW-1:0] sum;  // offset
    logic                 ena;
  } lin_cfg_t;

  typedef enum logic [1:0] {IDLE, ARMED, RUN, BURST_IDLE} asg_state_t;

  // register map
  localparam reg_adr_t REG_CTL     = 7'h00;
  localparam reg_adr_t REG_IRQ_ENA = 7'h08;
  localparam reg_adr_t REG_IRQ_STS = 7'h0c;
  localparam reg_adr_t REG_MSK_CLR = 7'h10;
  localparam reg_adr_t REG_MSK_STR = 7'h14;
  localparam reg_adr_t REG_MSK_STP = 7'h18;
  localparam reg_adr_t REG_MSK_TRG = 7'h1c;
  localparam reg_adr_t REG_SIZ     = 7'h20;
  localparam reg_adr_t REG_OFF     = 7'h24;
  localparam reg_adr_t REG_STE     = 7'h28;
  localparam reg_adr_t REG_BST     = 7'h30;
  localparam reg_adr_t REG_BDL     = 7'h34;
  localparam reg_adr_t REG_BLN     = 7'h38;
  localparam reg_adr_t REG_BNM     = 7'h3c;
  localparam reg_adr_t REG_STS_BLN = 7'h40;
  localparam reg_adr_t REG_STS_BNM = 7'h44;
  localparam reg_adr_t REG_MUL     = 7'h50;
  localparam reg_adr_t REG_SUM     = 7'h54;
  localparam reg_adr_t REG_ENA     = 7'h58;

endpackage

/* rtl/gen_regs.sv */
////////////////////////////////////////////////////////////
// generator register bank
// config and mask registers, software events, interrupts
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module gen_regs
  import gen_pkg::*;
#(
  parameter int unsigned EW = 6  // external event count
)(
  input  logic           bus,
  input  logic           ctl_rst,
  input  bus_req_t       reg_req,
  output bus_rsp_t       reg_rsp,
  input  logic [EW-1:0]  ev_ext,
  output ctl_t           evn_sw,   // software event pulses
  output ctl_t           ctl,      // masked events to the core
  input  logic           sts_str,
  input  logic           sts_trg,
  input  logic           sts_stp,
  input  logic [CWL-1:0] sts_bln,
  input  logic [CWN-1:0] sts_bnm,
  output gen_cfg_t       gen_cfg,
  output lin_cfg_t       lin_cfg,
  output logic           irq
);

  logic [EW-1:0] msk_clr;
  logic [EW-1:0] msk_str;
  logic [EW-1:0] msk_stp;
  logic [EW-1:0] msk_trg;
  logic [3:0]    irq_ena;
  logic [3:0]    irq_sts;  // {trg, stp, str, clr}
  logic          ack;
  logic [31:0]   rdata;
  logic [31:0]   rd_mux;
  reg_adr_t      adr;

  assign adr     = reg_req.addr[BAW-1:0];
  assign reg_rsp = '{ack: ack, rdata: rdata};

  // event select, same cycle to the core
  assign ctl.clr = |(ev_ext & msk_clr);
  assign ctl.str = |(ev_ext & msk_str);
  assign ctl.stp = |(ev_ext & msk_stp);
  assign ctl.trg = |(ev_ext & msk_trg);

  ////////////////////////////////////////////////////////////
  // write decode
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      irq_ena <= '0;
      msk_clr <= '0;
      msk_str <= '0;
      msk_stp <= '0;
      msk_trg <= '0;
      gen_cfg <= '0;
      lin_cfg <= '0;  // output disabled
    end else if (reg_req.wen) begin
      case (adr)
        REG_IRQ_ENA: irq_ena     <= reg_req.wdata[3:0];
        REG_MSK_CLR: msk_clr     <= reg_req.wdata[EW-1:0];
        REG_MSK_STR: msk_str     <= reg_req.wdata[EW-1:0];
        REG_MSK_STP: msk_stp     <= reg_req.wdata[EW-1:0];
        REG_MSK_TRG: msk_trg     <= reg_req.wdata[EW-1:0];
        REG_SIZ:     gen_cfg.siz <= reg_req.wdata[CW-1:0];
        REG_OFF:     gen_cfg.off <= reg_req.wdata[CW-1:0];
        REG_STE:     gen_cfg.ste <= reg_req.wdata[CW-1:0];
        REG_BST: begin
          gen_cfg.ben <= reg_req.wdata[0];
          gen_cfg.inf <= reg_req.wdata[1];
        end
        REG_BDL:     gen_cfg.bdl <= reg_req.wdata[CWM-1:0];
        REG_BLN:     gen_cfg.bln <= reg_req.wdata[CWL-1:0];
        REG_BNM:     gen_cfg.bnm <= reg_req.wdata[CWN-1:0];
        REG_MUL:     lin_cfg.mul <= reg_req.wdata[DW-1:0];
        REG_SUM:     lin_cfg.sum <= reg_req.wdata[DW-1:0];
        REG_ENA:     lin_cfg.ena <= reg_req.wdata[0];
        default: ;
      endcase
    end
  end

  // software events, one clock after the CTL write
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      evn_sw <= '0;
    end else if (reg_req.wen && adr == REG_CTL) begin
      evn_sw.clr <= reg_req.wdata[0];
      evn_sw.str <= reg_req.wdata[1];
      evn_sw.stp <= reg_req.wdata[2];
      evn_sw.trg <= reg_req.wdata[3];
    end else begin
      evn_sw <= '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////

  always_comb begin
    rd_mux = '0;  // unmapped reads zero
    case (adr)
      REG_CTL:     rd_mux = {28'd0, sts_trg, sts_stp, sts_str, 1'b0};
      REG_IRQ_ENA: rd_mux = 32'(irq_ena);
      REG_IRQ_STS: rd_mux = 32'(irq_sts);
      REG_MSK_CLR: rd_mux = 32'(msk_clr);
      REG_MSK_STR: rd_mux = 32'(msk_str);
      REG_MSK_STP: rd_mux = 32'(msk_stp);
      REG_MSK_TRG: rd_mux = 32'(msk_trg);
      REG_SIZ:     rd_mux = 32'(gen_cfg.siz);
      REG_OFF:     rd_mux = 32'(gen_cfg.off);
      REG_STE:     rd_mux = 32'(gen_cfg.ste);
      REG_BST:     rd_mux = {30'd0, gen_cfg.inf, gen_cfg.ben};
      REG_BDL:     rd_mux = 32'(gen_cfg.bdl);
      REG_BLN:     rd_mux = 32'(gen_cfg.bln);
      REG_BNM:     rd_mux = 32'(gen_cfg.bnm);
      REG_STS_BLN: rd_mux = 32'(sts_bln);
      REG_STS_BNM: rd_mux = 32'(sts_bnm);
      REG_MUL:     rd_mux = {{(32-DW){1'b0}}, lin_cfg.mul};  // masked, no sign
      REG_SUM:     rd_mux = {{(32-DW){1'b0}}, lin_cfg.sum};
      REG_ENA:     rd_mux = {31'd0, lin_cfg.ena};
      default: ;
    endcase
  end

  always_ff @(posedge bus) begin
    if (ctl_rst) ack <= 1'b0;
    else         ack <= reg_req.wen | reg_req.ren;
  end

  always_ff @(posedge bus) begin
    if (reg_req.ren) rdata <= rd_mux;
  end

  ////////////////////////////////////////////////////////////
  // interrupts
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      irq_sts <= '0;
    end else if (ctl.clr) begin
      irq_sts <= 4'b0001;  // wipe all, keep the clear itself
    end else if (reg_req.wen && adr == REG_IRQ_STS) begin
      irq_sts <= irq_sts & ~reg_req.wdata[3:0];  // write one to clear
    end else begin
      irq_sts <= irq_sts | {ctl.trg, ctl.stp, ctl.str, 1'b0};
    end
  end

  always_ff @(posedge bus) begin
    if (ctl_rst) irq <= 1'b0;
    else         irq <= |(irq_sts & irq_ena);
  end

endmodule

/* rtl/gen_table.sv */
////////////////////////////////////////////////////////////
// waveform table
// CPU read/write port, synchronous generator read port
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module gen_table
  import gen_pkg::*;
(
  input  logic     bus,
  input  bus_req_t tbl_req,
  output bus_rsp_t tbl_rsp,
  input  logic     rd_en,
  input  tbl_adr_t rd_adr,
  output smp_t     rd_dat
);

  smp_t        mem [2**CWM];
  tbl_adr_t    cpu_adr;  // word index
  logic        ack;
  logic [31:0] rdata;

  assign cpu_adr = tbl_req.addr[CWM-1:0];
  assign tbl_rsp = '{ack: ack, rdata: rdata};

  // CPU port
  always_ff @(posedge bus) begin
    if (tbl_req.wen) mem[cpu_adr] <= tbl_req.wdata[DW-1:0];
    if (tbl_req.ren) rdata <= 32'(mem[cpu_adr]);  // sign extended
  end

  // idle bus leaves ack low
  always_ff @(posedge bus) begin
    ack <= tbl_req.wen | tbl_req.ren;
  end

  // generator port, holds while stalled
  always_ff @(posedge bus) begin
    if (rd_en) rd_dat <= mem[rd_adr];
  end

endmodule

/* rtl/gen_asg.sv */
////////////////////////////////////////////////////////////
// generator core
// start/trigger/stop FSM, fixed point phase pointer,
// continuous wrap or counted burst, table read pipeline
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module gen_asg
  import gen_pkg::*;
(
  input  logic           bus,
  input  logic           ctl_rst,
  input  ctl_t           ctl,
  input  gen_cfg_t       cfg,
  input  logic           adv,         // pipeline advance
  input  smp_t           tbl_rd_dat,
  output logic           tbl_rd_en,
  output tbl_adr_t       tbl_rd_adr,
  output stm_t           smp_raw,
  output logic           sts_str,     // armed
  output logic           sts_trg,     // running
  output logic           sts_stp,     // stopped
  output logic [CWL-1:0] sts_bln,     // beat in period
  output logic [CWN-1:0] sts_bnm,     // periods done
  output logic           evn_per,
  output logic           evn_lst
);

  asg_state_t     state;
  ptr_t           ptr;
  logic [CW:0]    ptr_sum;  // spare bit for the wrap compare
  logic           ptr_wrp;
  ptr_t           ptr_nxt;
  logic [CWL-1:0] bln_nxt;
  logic [CWN-1:0] bnm_nxt;
  logic           dat_end;  // last table beat of the period
  logic           per_end;
  logic           bst_lst;
  logic           running;
  logic           halt;     // stop or clear this cycle
  logic           step;     // one beat taken
  logic           rd_vld;
  logic           rd_zro;   // burst idle beat
  logic           raw_vld;
  smp_t           raw_dat;

  assign running = (state == RUN) || (state == BURST_IDLE);
  assign halt    = ctl.clr | ctl.stp;
  assign step    = running && adv && !halt;

  assign sts_str = state == ARMED;
  assign sts_trg = running;

  // next pointer wraps at table size
  always_comb begin
    ptr_sum = {1'b0, ptr} + {1'b0, cfg.ste};
    ptr_wrp = ptr_sum >= {1'b0, cfg.siz};
    ptr_nxt = ptr_wrp ? ptr_t'(ptr_sum - {1'b0, cfg.siz}) : ptr_sum[CW-1:0];
  end

  assign bln_nxt = sts_bln + 1'b1;
  assign bnm_nxt = sts_bnm + 1'b1;
  assign dat_end = bln_nxt == CWL'(cfg.bdl);
  assign per_end = bln_nxt == cfg.bln;
  assign bst_lst = !cfg.inf && (bnm_nxt == cfg.bnm);

  ////////////////////////////////////////////////////////////
  // state machine and burst counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      state   <= IDLE;
      sts_bln <= '0;
      sts_bnm <= '0;
      sts_stp <= 1'b0;
      evn_per <= 1'b0;
      evn_lst <= 1'b0;
    end else begin
      evn_per <= 1'b0;
      evn_lst <= 1'b0;
      if (halt) begin
        state   <= IDLE;
        sts_stp <= !ctl.clr;
        if (ctl.clr) begin
          sts_bln <= '0;
          sts_bnm <= '0;
        end
      end else begin
        case (state)
          IDLE: if (ctl.str) begin
            state   <= ARMED;
            sts_stp <= 1'b0;
          end
          ARMED: if (ctl.trg) begin
            state   <= RUN;
            sts_bln <= '0;
            sts_bnm <= '0;
          end
          default: if (step) begin
            if (!cfg.ben) begin
              evn_per <= ptr_wrp;  // continuous mode pulses once per wrap
            end else if (per_end) begin
              sts_bln <= '0;
              sts_bnm <= bnm_nxt;
              evn_per <= 1'b1;
              evn_lst <= bst_lst;
              state   <= bst_lst ? IDLE : RUN;
            end else begin
              sts_bln <= bln_nxt;
              if (dat_end) state <= BURST_IDLE;  // zero beats till period end
            end
          end
        endcase
      end
    end
  end

  // phase pointer
  always_ff @(posedge bus) begin
    if (state == ARMED && ctl.trg) begin
      ptr <= cfg.off;
    end else if (step) begin
      if (cfg.ben && per_end) ptr <= cfg.off;  // restart each period
      else if (state == RUN)  ptr <= ptr_nxt;
    end
  end

  ////////////////////////////////////////////////////////////
  // table read and raw stream
  ////////////////////////////////////////////////////////////

  assign tbl_rd_en  = adv;
  assign tbl_rd_adr = ptr[CW-1:CWF];  // integer part
  assign smp_raw    = '{vld: raw_vld, dat: raw_dat};

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      rd_vld  <= 1'b0;
      rd_zro  <= 1'b0;
      raw_vld <= 1'b0;
    end else if (adv) begin
      rd_vld  <= step;
      rd_zro  <= state == BURST_IDLE;
      raw_vld <= rd_vld;
    end
  end

  always_ff @(posedge bus) begin
    if (adv) raw_dat <= rd_zro ? '0 : tbl_rd_dat;
  end

endmodule

/* rtl/gen_lin.sv */
////////////////////////////////////////////////////////////
// linear output stage
// gain, then offset with saturation and output enable
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module gen_lin
  import gen_pkg::*;
(
  input  logic     bus,
  input  logic     ctl_rst,
  input  lin_cfg_t cfg,
  input  stm_t     sti,
  output stm_t     sto,
  input  logic     sto_rdy,
  output logic     adv      // shared stall control
);

  typedef logic signed [DW+1:0] mul_t;  // scaled product
  typedef logic signed [DW+2:0] add_t;  // product plus offset

  localparam add_t SMP_MAX = add_t'(2**(DW-1) - 1);
  localparam add_t SMP_MIN = -add_t'(2**(DW-1));

  logic signed [2*DW-1:0] prd;
  mul_t                   mul_dat;
  logic                   mul_vld;
  add_t                   add;
  smp_t                   sat;
  logic                   out_vld;
  smp_t                   out_dat;

  // empty or accepted
  assign adv = !out_vld || sto_rdy;
  assign sto = '{vld: out_vld, dat: out_dat};
  assign prd = sti.dat * cfg.mul;

  always_comb begin
    add = mul_dat + cfg.sum;
    if (!cfg.ena)           sat = '0;
    else if (add > SMP_MAX) sat = smp_t'(SMP_MAX);
    else if (add < SMP_MIN) sat = smp_t'(SMP_MIN);
    else                    sat = smp_t'(add);
  end

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      mul_vld <= 1'b0;
      out_vld <= 1'b0;
    end else if (adv) begin
      mul_vld <= sti.vld;
      out_vld <= mul_vld;
    end
  end

  always_ff @(posedge bus) begin
    if (adv) begin
      mul_dat <= mul_t'(prd >>> (DW-2));  // 1.0 is 2**(DW-2)
      out_dat <= sat;
    end
  end

endmodule

/* rtl/gen_top.sv */
////////////////////////////////////////////////////////////
// arbitrary signal generator, one channel
// registers, waveform table, core and linear stage
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module gen_top
  import gen_pkg::*;
#(
  parameter int unsigned EW = 6  // external event count
)(
  input  logic          bus,
  input  logic          ctl_rst,
  input  bus_req_t      reg_req,
  output bus_rsp_t      reg_rsp,
  input  bus_req_t      tbl_req,
  output bus_rsp_t      tbl_rsp,
  input  logic [EW-1:0] ev_ext,
  output ctl_t          evn_sw,
  output stm_t          sto,
  input  logic          sto_rdy,
  output logic          evn_per,
  output logic          evn_lst,
  output logic          irq
);

  ctl_t           ctl;
  gen_cfg_t       gen_cfg;
  lin_cfg_t       lin_cfg;
  logic           sts_str;
  logic           sts_trg;
  logic           sts_stp;
  logic [CWL-1:0] sts_bln;
  logic [CWN-1:0] sts_bnm;
  logic           tbl_rd_en;
  tbl_adr_t       tbl_rd_adr;
  smp_t           tbl_rd_dat;
  stm_t           smp_raw;
  logic           adv;

  gen_regs #(
    .EW (EW)
  ) u_regs (
    .bus, .ctl_rst, .reg_req, .reg_rsp, .ev_ext, .evn_sw, .ctl,
    .sts_str, .sts_trg, .sts_stp, .sts_bln, .sts_bnm,
    .gen_cfg, .lin_cfg, .irq
  );

  gen_table u_table (
    .bus, .tbl_req, .tbl_rsp,
    .rd_en  (tbl_rd_en),
    .rd_adr (tbl_rd_adr),
    .rd_dat (tbl_rd_dat)
  );

  gen_asg u_asg (
    .bus, .ctl_rst, .ctl,
    .cfg (gen_cfg),
    .adv, .tbl_rd_dat, .tbl_rd_en, .tbl_rd_adr, .smp_raw,
    .sts_str, .sts_trg, .sts_stp, .sts_bln, .sts_bnm,
    .evn_per, .evn_lst
  );

  gen_lin u_lin (
    .bus, .ctl_rst,
    .cfg (lin_cfg),
    .sti (smp_raw),
    .sto, .sto_rdy, .adv
  );

endmodule

/* sim/gen_tb.sv */
////////////////////////////////////////////////////////////
// arbitrary signal generator testbench
// bus tasks, reference model of pointer, burst and gain,
// beat and event checks, watchdog
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module gen_tb
  import gen_pkg::*;
();

  // rough cycle budget per test
  localparam int LEN_REGS  = 150;
  localparam int LEN_LOAD  = 150;
  localparam int LEN_CONT  = 120;
  localparam int LEN_FRAC  = 200;
  localparam int LEN_BURST = 120;
  localparam int LEN_LIN   = 300;
  localparam int LEN_IRQ   = 120;
  localparam int WDOG_NS   = 2 * 40 * (LEN_REGS + LEN_LOAD + LEN_CONT + LEN_FRAC
                                       + LEN_BURST + LEN_LIN + LEN_IRQ) + 20000;

  logic       bus;
  logic       ctl_rst;
  bus_req_t   reg_req;
  bus_req_t   tbl_req;
  bus_rsp_t   reg_rsp;
  bus_rsp_t   tbl_rsp;
  logic [5:0] ev_ext;
  ctl_t       evn_sw;
  stm_t       sto;
  logic       sto_rdy;
  logic       evn_per;
  logic       evn_lst;
  logic       irq;
  logic       trg_pin;             // external trigger pin
  logic       rdy_rnd;             // random back-pressure on
  integer     seed = 32'h952c;

  // reference model state
  int    tbl_mdl [0:31];           // copy of the loaded table
  int    m_off;
  int    m_ste;
  int    m_siz;
  bit    m_ben;
  int    m_bdl;
  int    m_bln;
  int    m_bnm;
  int    m_mul;
  int    m_sum;
  bit    m_ena;
  int    m_ptr;
  int    m_bi;                     // beat within burst period
  int    m_per;
  int    m_lst;
  int    errors = 0;
  int    err_mark = 0;
  int    ntests = 0;
  int    n_acc = 0;                // accepted beats
  int    per_cnt = 0;
  int    lst_cnt = 0;
  string test_name = "reset";

  // loopback {clr, str, stp, trg} with the pin on bit 4 and bit 5 low
  assign ev_ext = {1'b0, trg_pin, evn_sw};

  gen_top #(
    .EW (6)
  ) UUT (
    .bus, .ctl_rst, .reg_req, .reg_rsp, .tbl_req, .tbl_rsp, .ev_ext,
    .evn_sw, .sto, .sto_rdy, .evn_per, .evn_lst, .irq
  );

  always #20 bus = ~bus;

  always @(negedge bus) begin
    sto_rdy = rdy_rnd ? (($random(seed) & 32'h3) != 0) : 1'b1;  // 3 of 4 ready
  end

  ////////////////////////////////////////////////////////////
  // checks and reference model
  ////////////////////////////////////////////////////////////

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("ERR %s %s expected 0x%h actual 0x%h", test_name, what, exp, act);
    end
  endtask

  function automatic logic [31:0] pat(input int a);
    return (32'h9e3779b9 * (a + 1)) ^ 32'h5a5a0f0f;  // per address
  endfunction

  // implemented bits per register or zero when unmapped or read only
  function automatic logic [31:0] cfg_mask(input logic [6:0] a);
    case (a)
      REG_IRQ_ENA: return 32'hf;
      REG_MSK_CLR, REG_MSK_STR, REG_MSK_STP, REG_MSK_TRG: return 32'h3f;
      REG_SIZ, REG_OFF, REG_STE: return 32'h3fff_ffff;
      REG_BST: return 32'h3;
      REG_BDL, REG_MUL, REG_SUM: return 32'h3fff;
      REG_BLN: return 32'hffff_ffff;
      REG_BNM: return 32'hffff;
      REG_ENA: return 32'h1;
      default: return 32'h0;
    endcase
  endfunction

  // gain of 2**12 is 1.0 then offset and clamp to 14 bit signed
  function automatic int lin_model(input int raw);
    int p;
    if (!m_ena) return 0;
    p = ((raw * m_mul) >>> 12) + m_sum;
    if (p > 8191) p = 8191;
    else if (p < -8192) p = -8192;
    return p;
  endfunction

  // each accepted beat takes one pointer step
  function int model_next();
    int raw;
    raw = 0;
    if (!m_ben || m_bi < m_bdl) begin
      raw = tbl_mdl[m_ptr >> 16];
      m_ptr = m_ptr + m_ste;
      if (m_ptr >= m_siz) begin
        m_ptr = m_ptr - m_siz;
        if (!m_ben) m_per++;  // continuous wrap
      end
    end
    if (m_ben) begin
      m_bi++;
      if (m_bi == m_bln) begin  // period end
        m_bi = 0;
        m_ptr = m_off;
        m_per++;
        if (m_per == m_bnm) m_lst++;
      end
    end
    return lin_model(raw);
  endfunction

  // beats and events taken at the clock edge
  always @(posedge bus) begin
    if (!ctl_rst) begin
      if (evn_per) per_cnt++;
      if (evn_lst) lst_cnt++;
      if (sto.vld && sto_rdy) begin
        check_eq($sformatf("beat %0d", n_acc), model_next(), sto.dat);
        n_acc++;
      end
    end
  end

  // stalled beat stays valid and unchanged
  assert property (@(posedge bus) disable iff (ctl_rst)
                   sto.vld && !sto_rdy |=> sto.vld && $stable(sto.dat))
    else begin
      errors++;
      $display("%s: stalled output beat changed before it was taken", test_name);
    end

  ////////////////////////////////////////////////////////////
  // bus and run tasks start and end on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic bus_xfer(input bit sel_tbl, input bit wr, input logic [31:0] adr,
                          input logic [31:0] dat, output logic [31:0] q);
    bus_req_t req;
    int       n;
    req = '0;
    req.wen = wr;
    req.ren = !wr;
    req.addr = adr;
    req.wdata = dat;
    if (sel_tbl) tbl_req = req;
    else reg_req = req;
    @(negedge bus);
    reg_req = '0;  // one cycle strobe
    tbl_req = '0;
    n = 1;
    while (!(sel_tbl ? tbl_rsp.ack : reg_rsp.ack) && n < 8) begin
      @(negedge bus);
      n++;
    end
    assert (n == 1) else begin
      errors++;
      $display("%s: bus ack missing one cycle after the strobe at 0x%h", test_name, adr);
    end
    q = sel_tbl ? tbl_rsp.rdata : reg_rsp.rdata;
  endtask

  task automatic reg_wr(input logic [31:0] a, input logic [31:0] d);
    logic [31:0] q;
    bus_xfer(1'b0, 1'b1, a, d, q);
  endtask

  task automatic reg_rd(input logic [31:0] a, output logic [31:0] q);
    bus_xfer(1'b0, 1'b0, a, 32'h0, q);
  endtask

  task automatic tbl_wr(input logic [31:0] a, input logic [31:0] d);
    logic [31:0] q;
    bus_xfer(1'b1, 1'b1, a, d, q);
  endtask

  task automatic tbl_rd(input logic [31:0] a, output logic [31:0] q);
    bus_xfer(1'b1, 1'b0, a, 32'h0, q);
  endtask

  task automatic set_gen(input int off, input int ste, input int siz);
    reg_wr(REG_OFF, off);
    reg_wr(REG_STE, ste);
    reg_wr(REG_SIZ, siz);
    m_off = off;
    m_ste = ste;
    m_siz = siz;
  endtask

  task automatic set_burst(input bit ben, input int bdl, input int bln, input int bnm);
    reg_wr(REG_BST, ben);  // inf left clear
    reg_wr(REG_BDL, bdl);
    reg_wr(REG_BLN, bln);
    reg_wr(REG_BNM, bnm);
    m_ben = ben;
    m_bdl = bdl;
    m_bln = bln;
    m_bnm = bnm;
  endtask

  task automatic set_lin(input int mul, input int sum, input bit ena);
    reg_wr(REG_MUL, mul);
    reg_wr(REG_SUM, sum);
    reg_wr(REG_ENA, ena);
    m_mul = mul;
    m_sum = sum;
    m_ena = ena;
  endtask

  task automatic model_reset();
    m_ptr = m_off;
    m_bi = 0;
    m_per = 0;
    m_lst = 0;
    n_acc = 0;
    per_cnt = 0;
    lst_cnt = 0;
  endtask

  task automatic wait_beats(input int n);
    int t;
    t = 0;
    while (n_acc < n && t < 40 * n) begin
      @(negedge bus);
      t++;
    end
    if (n_acc < n) begin
      errors++;
      $display("%s: timed out after %0d of %0d beats", test_name, n_acc, n);
    end
  endtask

  task automatic wait_last();
    int t;
    t = 0;
    while (lst_cnt == 0 && t < 400) begin
      @(negedge bus);
      t++;
    end
    if (lst_cnt == 0) begin
      errors++;
      $display("%s: last burst event never came", test_name);
    end
  endtask

  // pipeline empty once valid stays low a while
  task automatic drain();
    int quiet;
    int t;
    rdy_rnd = 1'b0;
    quiet = 0;
    t = 0;
    while (quiet < 6 && t < 100) begin
      @(negedge bus);
      quiet = sto.vld ? 0 : quiet + 1;
      t++;
    end
    if (quiet < 6) begin
      errors++;
      $display("%s: output stream did not go idle", test_name);
    end
  endtask

  task automatic wait_irq(input logic lvl);
    int t;
    t = 0;
    while (irq !== lvl && t < 10) begin
      @(negedge bus);
      t++;
    end
    if (irq !== lvl) begin
      errors++;
      $display("%s: irq did not go to %0b", test_name, lvl);
    end
  endtask

  // start and trigger, take n beats, stop and count wraps
  task automatic play(input int n);
    model_reset();
    reg_wr(REG_CTL, 32'h2);
    reg_wr(REG_CTL, 32'h8);
    wait_beats(n);
    reg_wr(REG_CTL, 32'h4);
    drain();
    check_eq("evn_per count", m_per, per_cnt);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark = errors;
    n_acc = 0;
  endtask

  task automatic end_test();
    $display("test %s %0d beats, %0d errors", test_name, n_acc, errors - err_mark);
    ntests++;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] q;
    int          v;
    bus = 1'b0;
    ctl_rst = 1'b1;
    reg_req = '0;
    tbl_req = '0;
    trg_pin = 1'b0;
    rdy_rnd = 1'b0;
    sto_rdy = 1'b1;
    repeat (5) @(negedge bus);
    ctl_rst = 1'b0;

    start_test("regs");  // whole map with unmapped and status reading zero
    for (int a = 8; a < 128; a += 4) reg_wr(a, pat(a));
    for (int a = 8; a < 128; a += 4) begin
      reg_rd(a, q);
      check_eq($sformatf("reg 0x%h", a), pat(a) & cfg_mask(a), q);
    end
    end_test();

    start_test("table");
    for (int i = 0; i < 32; i++) begin
      tbl_mdl[i] = i * 250 - 3900;  // ramp
      tbl_wr(i, tbl_mdl[i]);
    end
    for (int i = 0; i < 32; i++) begin
      tbl_rd(i, q);
      check_eq($sformatf("word %0d", i), tbl_mdl[i], q);  // sign extended
    end
    end_test();

    reg_wr(REG_MSK_CLR, 32'h08);
    reg_wr(REG_MSK_STR, 32'h04);
    reg_wr(REG_MSK_STP, 32'h02);
    reg_wr(REG_MSK_TRG, 32'h01);
    reg_wr(REG_IRQ_ENA, 32'h0);
    set_burst(1'b0, 0, 0, 0);
    set_lin(4096, 0, 1'b1);  // unity gain

    start_test("cont");
    set_gen(3 << 16, 1 << 16, 16 << 16);
    play(40);
    end_test();

    start_test("frac");
    set_gen(0, 32'h6000, 16 << 16);  // step 0.375
    rdy_rnd = 1'b1;
    play(60);
    end_test();

    start_test("burst");
    set_gen(2 << 16, 1 << 16, 16 << 16);
    set_burst(1'b1, 5, 8, 3);
    reg_wr(REG_MSK_TRG, 32'h10);  // pin only
    model_reset();
    rdy_rnd = 1'b1;
    reg_wr(REG_CTL, 32'h2);
    @(negedge bus);  // armed on this edge
    trg_pin = 1'b1;
    @(negedge bus);
    trg_pin = 1'b0;
    wait_last();
    drain();
    check_eq("beats", 24, n_acc);
    check_eq("evn_per count", 3, per_cnt);
    check_eq("evn_lst count", m_lst, lst_cnt);
    reg_rd(REG_STS_BNM, q);
    check_eq("sts_bnm", 3, q);
    reg_wr(REG_MSK_TRG, 32'h01);
    set_burst(1'b0, 0, 0, 0);
    end_test();

    start_test("lin");
    set_gen(0, 1 << 16, 32 << 16);
    set_lin(8191, 4000, 1'b1);  // just under 2.0 so it clips high
    play(40);
    set_lin(8191, -4000, 1'b1);  // clips low
    play(40);
    set_lin(4096, 0, 1'b0);  // disabled output gives zero beats
    play(20);
    set_lin(4096, 0, 1'b1);
    end_test();

    start_test("irq");
    set_gen(0, 1 << 16, 16 << 16);
    reg_wr(REG_IRQ_ENA, 32'he);
    reg_wr(REG_IRQ_STS, 32'hf);
    wait_irq(1'b0);
    model_reset();
    reg_wr(REG_CTL, 32'h2);
    wait_irq(1'b1);
    reg_rd(REG_IRQ_STS, q);
    check_eq("irq_sts after start", 32'h2, q);
    reg_wr(REG_CTL, 32'h8);
    wait_beats(10);
    reg_rd(REG_IRQ_STS, q);
    check_eq("irq_sts after trigger", 32'ha, q);
    reg_wr(REG_CTL, 32'h4);
    drain();
    v = n_acc;
    reg_rd(REG_IRQ_STS, q);
    check_eq("irq_sts after stop", 32'he, q);
    reg_wr(REG_IRQ_STS, 32'he);
    wait_irq(1'b0);
    reg_rd(REG_IRQ_STS, q);
    check_eq("irq_sts cleared", 32'h0, q);
    check_eq("beats after stop", v, n_acc);
    end_test();

    $display("tests %0d, errors %0d", ntests, errors);
    if (errors == 0) $display("Finished with no errors");
    else $display("Finished with errors");
    $finish;
  end

  initial begin
    #(WDOG_NS);
    $display("watchdog: the run went past its time limit");
    $display("Finished with errors");
    $finish;
  end

endmodule

/* gen_top.f */
rtl/gen_pkg.sv
rtl/gen_regs.sv
rtl/gen_table.sv
rtl/gen_asg.sv
rtl/gen_lin.sv
rtl/gen_top.sv
sim/gen_tb.sv

/* Bender.yml */
package:
  name: gen_top

sources:
  - rtl/gen_pkg.sv
  - rtl/gen_regs.sv
  - rtl/gen_table.sv
  - rtl/gen_asg.sv
  - rtl/gen_lin.sv
  - rtl/gen_top.sv
  - target: test
    files:
      - sim/gen_tb.sv
